// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_board_specific_top \
		-f sim.f -Mdir obj_dir -o sim_tb
	-./obj_dir/sim_tb +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG) || (echo "FAIL: run ended early"; exit 1)
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)

// ==== rtl/audio_pkg.sv ====
// Samples are left-channel INMP441 words, two's complement, MSB first on the wire
`include "board_macros.svh"

package audio_pkg;

    // ------------------------------
    // Microphone sample types

    typedef logic signed [`MIC_BITS - 1:0] mic_sample_t;

    // No ready: a beat that is not taken is lost
    typedef struct packed {
        logic        valid;     // One-cycle pulse per sample
        mic_sample_t sample;
    } mic_beat_t;

endpackage

// ==== rtl/board_macros.svh ====
// Dividers count clk cycles per half period of the serial clock and must be at least 2
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// ------------------------------
// Serial clock dividers

`define TM_CLK_DIV   4    // clk cycles per half period of tm_clk
`define MIC_SCK_DIV  4    // clk cycles per half period of mic_sck

// ------------------------------
// Panel and microphone sizes

`define TM_DIGITS    8    // Seven-segment digits on the TM1638 panel
`define MIC_BITS     24   // Significant bits in an INMP441 sample

`endif

// ==== rtl/board_specific_top.sv ====
// TM1638 data line is split into in, out and enable; the board pad joins them
module board_specific_top
    import panel_pkg::*;
    import audio_pkg::*;
(
    input  logic clk,
    input  logic arst_n,

    output logic tm_clk,
    output logic tm_stb,
    output logic tm_dio_out,
    output logic tm_dio_oe,
    input  logic tm_dio_in,

    output logic mic_sck,
    output logic mic_ws,
    output logic mic_lr,
    input  logic mic_sd
);

    mic_beat_t mic_beat;
    tm_keys_t  tm_keys;
    tm_frame_t tm_frame;
    logic      frame_valid;
    logic      frame_ready;

    // ------------------------------
    // Microphone

    inmp441_mic_i2s_receiver u_mic
    (
        .clk     ( clk      ),
        .arst_n  ( arst_n   ),
        .mic_sd  ( mic_sd   ),
        .mic_sck ( mic_sck  ),
        .mic_ws  ( mic_ws   ),
        .mic_lr  ( mic_lr   ),
        .beat    ( mic_beat )
    );

    // ------------------------------
    // Lab design

    level_display u_display
    (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .beat        ( mic_beat    ),
        .keys        ( tm_keys     ),
        .frame       ( tm_frame    ),
        .frame_valid ( frame_valid ),
        .frame_ready ( frame_ready )
    );

    // ------------------------------
    // Panel

    tm1638_board_controller u_tm1638
    (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .frame       ( tm_frame    ),
        .frame_valid ( frame_valid ),
        .frame_ready ( frame_ready ),
        .keys        ( tm_keys     ),
        .keys_valid  (             ),   // Keys are held, the pulse is not needed here
        .tm_clk      ( tm_clk      ),
        .tm_stb      ( tm_stb      ),
        .tm_dio_out  ( tm_dio_out  ),
        .tm_dio_oe   ( tm_dio_oe   ),
        .tm_dio_in   ( tm_dio_in   )
    );

endmodule

// ==== rtl/inmp441_mic_i2s_receiver.sv ====
// Left channel only with mic_lr tied low; 64 mic_sck periods per word-select period
`include "board_macros.svh"

module inmp441_mic_i2s_receiver
    import audio_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      mic_sd,
    output logic      mic_sck,
    output logic      mic_ws,
    output logic      mic_lr,
    output mic_beat_t beat
);

    localparam int DIV   = `MIC_SCK_DIV;
    localparam int DIV_W = $clog2(DIV);

    logic [DIV_W - 1:0] div_cnt;
    logic               tick;
    logic               sck_rise;
    logic               sck_fall;
    logic [5:0]         bit_cnt;        // mic_sck periods within one word-select period
    logic               capture;
    logic               valid_q;
    mic_sample_t        shift_q;

    // ------------------------------
    // Bit clock and word select

    assign tick     = (div_cnt == DIV_W'(DIV - 1));
    assign sck_rise = tick && !mic_sck;
    assign sck_fall = tick && mic_sck;
    assign mic_ws   = bit_cnt[5];       // Low for the left word
    assign mic_lr   = 1'b0;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            div_cnt <= '0;
            mic_sck <= 1'b0;
            bit_cnt <= 6'd63;           // First falling edge starts a left word
        end
        else
        begin
            if (tick)
            begin
                div_cnt <= '0;
                mic_sck <= !mic_sck;
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
            end

            if (sck_fall)
                bit_cnt <= bit_cnt + 6'd1;  // mic_ws moves with the falling edge
        end
    end

    // ------------------------------
    // Left-channel capture

    // One-bit delay after mic_ws falls, then MSB first
    assign capture = sck_rise && (bit_cnt >= 6'd1) && (bit_cnt <= 6'(`MIC_BITS));

    always_ff @(posedge clk)
    begin
        if (capture)
            shift_q <= {shift_q[`MIC_BITS - 2:0], mic_sd};
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            valid_q <= 1'b0;
        else
            valid_q <= capture && (bit_cnt == 6'(`MIC_BITS));
    end

    assign beat = '{valid: valid_q, sample: shift_q};

endmodule

// ==== rtl/level_display.sv ====
// Key 0 freezes the shown sample; samples arriving while it is held are dropped
`include "board_macros.svh"

module level_display
    import panel_pkg::*;
    import audio_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  mic_beat_t beat,
    input  tm_keys_t  keys,
    output tm_frame_t frame,
    output logic      frame_valid,
    input  logic      frame_ready
);

    localparam int   HEX_DIGITS = `MIC_BITS / 4;
    localparam seg_t SEG_BLANK  = 8'h00;
    localparam seg_t SEG_H      = 8'h76;

    mic_sample_t           sample_q;    // Last accepted sample
    logic                  hold;
    logic                  hold_q;      // Hold state shown on the panel
    logic [`MIC_BITS - 1:0] magnitude;

    // Standard hex font with lowercase b and d
    function automatic seg_t hex_seg(input logic [3:0] nibble);
        case (nibble)
            4'h0:    hex_seg = 8'h3F;
            4'h1:    hex_seg = 8'h06;
            4'h2:    hex_seg = 8'h5B;
            4'h3:    hex_seg = 8'h4F;
            4'h4:    hex_seg = 8'h66;
            4'h5:    hex_seg = 8'h6D;
            4'h6:    hex_seg = 8'h7D;
            4'h7:    hex_seg = 8'h07;
            4'h8:    hex_seg = 8'h7F;
            4'h9:    hex_seg = 8'h6F;
            4'hA:    hex_seg = 8'h77;
            4'hB:    hex_seg = 8'h7C;
            4'hC:    hex_seg = 8'h39;
            4'hD:    hex_seg = 8'h5E;
            4'hE:    hex_seg = 8'h79;
            default: hex_seg = 8'h71;
        endcase
    endfunction

    assign hold = keys[0];

    // ------------------------------
    // Sample and handshake

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sample_q    <= '0;
            hold_q      <= 1'b0;
            frame_valid <= 1'b0;
        end
        else
        begin
            hold_q <= hold;
            if (beat.valid && !hold)
            begin
                sample_q    <= beat.sample;
                frame_valid <= 1'b1;        // Overwrites a frame still waiting
            end
            else if (hold != hold_q)
                frame_valid <= 1'b1;        // Digit 7 changes
            else if (frame_ready)
                frame_valid <= 1'b0;
        end
    end

    // ------------------------------
    // Display image

    // Most negative value maps to 2**23
    assign magnitude = sample_q[`MIC_BITS - 1] ? $unsigned(-sample_q) : $unsigned(sample_q);

    always_comb
    begin
        for (int d = 0; d < HEX_DIGITS; d++)
            frame.digits[d] = hex_seg(sample_q[`MIC_BITS - 1 - 4 * d -: 4]);
        frame.digits[`TM_DIGITS - 2] = SEG_BLANK;
        frame.digits[`TM_DIGITS - 1] = hold_q ? SEG_H : SEG_BLANK;

        // LED i lights from 2**(16+i) upward
        for (int i = 0; i < 8; i++)
            frame.leds[i] = |(magnitude >> (`MIC_BITS - 8 + i));
    end

endmodule

// ==== rtl/panel_pkg.sv ====
// Segment bytes are hgfedcba with bit 0 as segment a, and digit 0 is the leftmost digit
`include "board_macros.svh"

package panel_pkg;

    // ------------------------------
    // Panel vectors

    typedef logic [7:0] seg_t;        // Bit 7 is the decimal point
    typedef logic [7:0] tm_keys_t;    // Bit k set while key k is pressed
    typedef logic [7:0] tm_leds_t;    // Bit i lights LED i

    // ------------------------------
    // One complete display image, 72 bits

    typedef struct packed {
        seg_t [`TM_DIGITS - 1:0] digits;    // digits[0] is the leftmost digit
        tm_leds_t                leds;
    } tm_frame_t;

endpackage

// ==== rtl/tm1638_board_controller.sv ====
// Static digit load only; key bytes are clocked right after command 0x42 with no wait time
`include "board_macros.svh"

module tm1638_board_controller
    import panel_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  tm_frame_t frame,
    input  logic      frame_valid,
    output logic      frame_ready,
    output tm_keys_t  keys,
    output logic      keys_valid,
    output logic      tm_clk,
    output logic      tm_stb,
    output logic      tm_dio_out,
    output logic      tm_dio_oe,
    input  logic      tm_dio_in
);

    localparam int DIV        = `TM_CLK_DIV;
    localparam int DIV_W      = $clog2(DIV);
    localparam int DATA_BYTES = 2 * `TM_DIGITS;    // Digit and LED byte per position
    localparam int BYTE_W     = $clog2(DATA_BYTES);
    localparam int KEY_BYTES  = 4;

    localparam logic [7:0] CMD_WRITE   = 8'h40;    // Auto-increment write
    localparam logic [7:0] CMD_ADDR    = 8'hC0;    // Start at address 0
    localparam logic [7:0] CMD_DISPLAY = 8'h8F;    // Display on, full brightness
    localparam logic [7:0] CMD_READ    = 8'h42;    // Key scan read

    typedef enum logic [2:0] {
        S_IDLE, S_CMD, S_ADDR, S_DATA, S_CTRL, S_READ, S_GAP
    } state_t;

    state_t              state;
    state_t              after_gap;     // Command that follows a strobe gap
    state_t              gap_target;
    logic [DIV_W - 1:0]  div_cnt;
    logic                tick;          // One cycle per half period of tm_clk
    logic [1:0]          gap_cnt;
    logic                phase;         // Low: next tick drops tm_clk
    logic [2:0]          bit_cnt;
    logic [BYTE_W - 1:0] byte_cnt;
    logic [BYTE_W - 1:0] byte_inc;
    logic [7:0]          shift_q;
    logic [7:0]          shift_next;
    logic [7:0]          gap_byte;
    logic                reading;
    logic [1:0]          key_idx;
    tm_frame_t           frame_q;       // Frame being sent
    tm_keys_t            keys_acc;
    tm_keys_t            keys_next;

    function automatic logic [7:0] command_byte(input state_t s);
        case (s)
            S_ADDR:  command_byte = CMD_ADDR;
            S_CTRL:  command_byte = CMD_DISPLAY;
            S_READ:  command_byte = CMD_READ;
            default: command_byte = CMD_WRITE;
        endcase
    endfunction

    // Even addresses carry segments, odd ones one LED in bit 0
    function automatic logic [7:0] data_byte(input tm_frame_t f, input logic [BYTE_W - 1:0] idx);
        if (idx[0])
            data_byte = {7'd0, f.leds[idx[BYTE_W - 1:1]]};
        else
            data_byte = f.digits[idx[BYTE_W - 1:1]];
    endfunction

    // ------------------------------
    // Half-period divider

    assign tick = (div_cnt == DIV_W'(DIV - 1));

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            div_cnt <= '0;
        else if (tick)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // ------------------------------
    // Byte sequencing

    assign gap_target  = (state == S_IDLE) ? S_CMD : after_gap;
    assign gap_byte    = command_byte(gap_target);
    assign frame_ready = (state == S_IDLE) && tick && (gap_cnt == 2'd2);
    assign reading     = (state == S_READ) && (byte_cnt != '0);
    assign shift_next  = {tm_dio_in, shift_q[7:1]};   // LSB first in both directions
    assign byte_inc    = byte_cnt + 1'b1;
    assign key_idx     = 2'(byte_cnt - 1'b1);

    // Byte j: bit 0 is key j, bit 4 is key j+4
    always_comb
    begin
        keys_next                   = keys_acc;
        keys_next[{1'b0, key_idx}]  = shift_next[0];
        keys_next[{1'b1, key_idx}]  = shift_next[4];
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state      <= S_IDLE;
            after_gap  <= S_CMD;
            gap_cnt    <= 2'd0;
            phase      <= 1'b0;
            bit_cnt    <= 3'd0;
            byte_cnt   <= '0;
            shift_q    <= 8'd0;
            frame_q    <= '0;       // Blank panel until a frame is taken
            keys_acc   <= '0;
            keys       <= '0;
            keys_valid <= 1'b0;
            tm_clk     <= 1'b1;
            tm_stb     <= 1'b1;
            tm_dio_out <= 1'b1;
            tm_dio_oe  <= 1'b0;
        end
        else
        begin
            keys_valid <= 1'b0;

            if (frame_ready && frame_valid)
                frame_q <= frame;   // Otherwise the last frame repeats

            if (tick)
            begin
                case (state)
                    S_IDLE, S_GAP:
                    begin
                        gap_cnt <= gap_cnt + 2'd1;
                        if (gap_cnt == 2'd0)
                        begin
                            tm_stb     <= 1'b1;     // tm_clk has been high for a half period
                            tm_dio_oe  <= 1'b0;
                            tm_dio_out <= 1'b1;
                        end
                        else if (gap_cnt == 2'd2)
                        begin
                            tm_stb   <= 1'b0;       // Next half is strobe setup
                            state    <= gap_target;
                            shift_q  <= gap_byte;
                            gap_cnt  <= 2'd0;
                            phase    <= 1'b0;
                            bit_cnt  <= 3'd0;
                            byte_cnt <= '0;
                        end
                    end

                    default:
                    begin
                        if (!phase)
                        begin
                            tm_clk     <= 1'b0;     // Data changes while tm_clk is low
                            tm_dio_oe  <= !reading;
                            tm_dio_out <= shift_q[0];
                            phase      <= 1'b1;
                        end
                        else
                        begin
                            tm_clk  <= 1'b1;        // Panel samples on this edge
                            phase   <= 1'b0;
                            shift_q <= shift_next;
                            bit_cnt <= bit_cnt + 3'd1;

                            if (bit_cnt == 3'd7)
                            begin
                                case (state)
                                    S_CMD:
                                    begin
                                        state     <= S_GAP;
                                        after_gap <= S_ADDR;
                                    end
                                    S_ADDR:
                                    begin
                                        state    <= S_DATA;
                                        byte_cnt <= '0;
                                        shift_q  <= data_byte(frame_q, '0);
                                    end
                                    S_DATA:
                                    begin
                                        if (byte_cnt == BYTE_W'(DATA_BYTES - 1))
                                        begin
                                            state     <= S_GAP;
                                            after_gap <= S_CTRL;
                                        end
                                        else
                                        begin
                                            byte_cnt <= byte_inc;
                                            shift_q  <= data_byte(frame_q, byte_inc);
                                        end
                                    end
                                    S_CTRL:
                                    begin
                                        state     <= S_GAP;
                                        after_gap <= S_READ;
                                    end
                                    S_READ:
                                    begin
                                        byte_cnt <= byte_inc;
                                        if (reading)
                                            keys_acc <= keys_next;
                                        if (byte_cnt == BYTE_W'(KEY_BYTES))
                                        begin
                                            keys       <= keys_next;    // Publish once per frame
                                            keys_valid <= 1'b1;
                                            state      <= S_IDLE;
                                        end
                                    end
                                    default: state <= S_IDLE;
                                endcase
                            end
                        end
                    end
                endcase
            end
        end
    end

endmodule

// ==== sim.f ====
+incdir+rtl
rtl/panel_pkg.sv
rtl/audio_pkg.sv
rtl/inmp441_mic_i2s_receiver.sv
rtl/level_display.sv
rtl/tm1638_board_controller.sv
rtl/board_specific_top.sv
test/board_specific_top_assert.sv
test/tb_board_specific_top.sv

// ==== test/board_specific_top_assert.sv ====
// Rules hold only while arst_n is high; pins an instance does not watch are tied to idle levels
module board_specific_top_assert
(
    input logic clk,
    input logic arst_n,
    input logic tm_clk,
    input logic tm_stb,
    input logic tm_dio_oe,
    input logic mic_sck,
    input logic mic_ws
);

    int failures = 0;   // Read by the testbench at the end of the run

    // ------------------------------
    // TM1638 serial link

    dio_released_while_idle: assert property (
        @(posedge clk) disable iff (!arst_n) tm_stb |-> !tm_dio_oe
    )
    else
    begin
        $error("tm_dio_oe is high while tm_stb is high");
        failures++;
    end

    clk_high_at_strobe_rise: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(tm_stb) |-> tm_clk
    )
    else
    begin
        $error("tm_stb rose while tm_clk was low");
        failures++;
    end

    // ------------------------------
    // I2S word select

    ws_moves_with_sck_low: assert property (
        @(posedge clk) disable iff (!arst_n) (mic_ws != $past(mic_ws)) |-> !mic_sck
    )
    else
    begin
        $error("mic_ws changed while mic_sck was high");
        failures++;
    end

endmodule

bind tm1638_board_controller board_specific_top_assert u_panel_assert
(
    .clk       ( clk       ),
    .arst_n    ( arst_n    ),
    .tm_clk    ( tm_clk    ),
    .tm_stb    ( tm_stb    ),
    .tm_dio_oe ( tm_dio_oe ),
    .mic_sck   ( 1'b0      ),   // Microphone pins at rest
    .mic_ws    ( 1'b1      )
);

bind inmp441_mic_i2s_receiver board_specific_top_assert u_mic_assert
(
    .clk       ( clk       ),
    .arst_n    ( arst_n    ),
    .tm_clk    ( 1'b1      ),   // Panel pins at rest
    .tm_stb    ( 1'b1      ),
    .tm_dio_oe ( 1'b0      ),
    .mic_sck   ( mic_sck   ),
    .mic_ws    ( mic_ws    )
);

// ==== test/tb_board_specific_top.sv ====
// Waits scale with TM_CLK_DIV and MIC_SCK_DIV; the panel model expects frames repeated back to back
`include "board_macros.svh"

module tb_board_specific_top
    import panel_pkg::*;
    import audio_pkg::*;
();

    localparam int PERIOD       = 100;
    localparam int FRAME_CYCLES = (24 * 16 + 4 * 3) * `TM_CLK_DIV;   // 24 bytes, 4 strobe gaps
    localparam int FIXED_ROWS   = 10;
    localparam int NUM_ROWS     = FIXED_ROWS + 20;
    // Four frames per row, with margin for frame and word alignment
    localparam int WATCHDOG_TIME = (NUM_ROWS * 4 + NUM_ROWS * 2 + 8) * FRAME_CYCLES * PERIOD;

    typedef struct packed {
        mic_sample_t sample;
        tm_keys_t    key_mask;
        logic        held;          // Display keeps the previous sample
        logic        rnd;           // Sample is drawn at random
    } row_t;

    logic clk       = 1'b0;
    logic arst_n    = 1'b0;
    logic mic_sd    = 1'b0;
    logic tm_dio_in = 1'b1;         // Line idles high
    logic tm_clk, tm_stb, tm_dio_out, tm_dio_oe;
    logic mic_sck, mic_ws, mic_lr;

    row_t        rows [NUM_ROWS];
    logic [7:0]  font [16];
    int          seed;
    mic_sample_t cur_sample = '0;   // Word the I2S source sends
    tm_keys_t    key_mask   = '0;   // Keys pressed on the panel model

    // ------------------------------
    // Model state

    logic       prev_sck     = 1'b0;
    logic       prev_ws      = 1'b1;
    logic       prev_tm_clk  = 1'b1;
    logic       prev_tm_stb  = 1'b1;
    int         mic_pos      = 63;
    int         words_sent   = 0;
    int         bit_idx      = 0;
    int         frame_count  = 0;
    logic [7:0] shreg        = 8'h00;
    logic [7:0] cur_cmd      = 8'h00;
    logic [7:0] image [16];
    logic [7:0] shown [16];         // Image of the last complete frame
    logic [7:0] cmd_log [$];
    logic       next_sd;
    logic       next_dio;

    board_specific_top u_board_specific_top
    (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .tm_clk     ( tm_clk     ),
        .tm_stb     ( tm_stb     ),
        .tm_dio_out ( tm_dio_out ),
        .tm_dio_oe  ( tm_dio_oe  ),
        .tm_dio_in  ( tm_dio_in  ),
        .mic_sck    ( mic_sck    ),
        .mic_ws     ( mic_ws     ),
        .mic_lr     ( mic_lr     ),
        .mic_sd     ( mic_sd     )
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic check(input string name, input logic [7:0] actual, input logic [7:0] expected);
        if (actual !== expected)
        begin
            $display("mismatch at time %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Test failed");
            $fatal(1, "value check failed");
        end
    endtask

    // Byte j of a key read: bit 0 is key j, bit 4 is key j+4
    function automatic logic key_line_bit(input int idx);
        if (idx % 8 == 0)
            key_line_bit = key_mask[idx / 8];
        else if (idx % 8 == 4)
            key_line_bit = key_mask[idx / 8 + 4];
        else
            key_line_bit = 1'b0;
    endfunction

    task automatic decode_panel_byte(input int n, input logic [7:0] b);
        if (n == 1)
        begin
            cur_cmd = b;
            cmd_log.push_back(b);
        end
        else if (cur_cmd == 8'hC0 && n <= 17)
            image[n - 2] = b;       // Auto-increment from address 0
        else if (cur_cmd == 8'h42 && n == 5)
        begin
            shown       = image;    // Last key byte closes the frame
            frame_count = frame_count + 1;
        end
    endtask

    // ------------------------------
    // I2S source and TM1638 panel models

    always @(posedge clk)
    begin
        next_sd  = mic_sd;
        next_dio = tm_dio_in;

        if (prev_sck && !mic_sck)
        begin
            if (prev_ws && !mic_ws)
                mic_pos = 0;        // Left word starts, one slot before the MSB
            else
                mic_pos = mic_pos + 1;
            if (mic_pos == 25)
                words_sent = words_sent + 1;
            next_sd = (mic_pos >= 1 && mic_pos <= 24) ? cur_sample[24 - mic_pos] : 1'b0;
        end

        if (prev_tm_stb && !tm_stb)
        begin
            bit_idx = 0;
            cur_cmd = 8'h00;
        end
        if (!tm_stb && !prev_tm_clk && tm_clk)
        begin
            // Controller drives the line except during key bytes
            check("tm_dio_oe", {7'd0, tm_dio_oe},
                  {7'd0, !(cur_cmd == 8'h42 && bit_idx >= 8)});
            shreg   = {tm_dio_out, shreg[7:1]};    // LSB first
            bit_idx = bit_idx + 1;
            if (bit_idx % 8 == 0)
                decode_panel_byte(bit_idx / 8, shreg);
        end
        if (!tm_stb && prev_tm_clk && !tm_clk && cur_cmd == 8'h42 && bit_idx >= 8)
            next_dio = key_line_bit(bit_idx - 8);

        prev_sck    = mic_sck;
        prev_ws     = mic_ws;
        prev_tm_clk = tm_clk;
        prev_tm_stb = tm_stb;

        #5;
        mic_sd    = next_sd;
        tm_dio_in = next_dio;
    end

    task automatic compare_image(input mic_sample_t s, input logic held);
        logic [24:0] mag;

        mag = s[23] ? 25'h1000000 - {1'b0, s} : {1'b0, s};
        for (int d = 0; d < 6; d++)
            check($sformatf("digit %0d", d), shown[2 * d], font[s[23 - 4 * d -: 4]]);
        check("digit 6", shown[12], 8'h00);
        check("digit 7", shown[14], held ? 8'h76 : 8'h00);
        for (int i = 0; i < 8; i++)
            check($sformatf("led %0d", i), shown[2 * i + 1], {7'd0, mag >= (25'd1 << (16 + i))});
    endtask

    // ------------------------------
    // Stimulus

    initial
    begin
        int          fbase;
        int          wbase;
        int          failures;
        mic_sample_t shown_sample;

        seed = 32'hfa52f2d6;
        font = '{8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66, 8'h6D, 8'h7D, 8'h07,
                 8'h7F, 8'h6F, 8'h77, 8'h7C, 8'h39, 8'h5E, 8'h79, 8'h71};
        rows[0] = '{24'h000000, 8'h00, 1'b0, 1'b0};
        rows[1] = '{24'h7FFFFF, 8'h00, 1'b0, 1'b0};
        rows[2] = '{24'h800000, 8'h00, 1'b0, 1'b0};
        rows[3] = '{24'h123456, 8'h00, 1'b0, 1'b0};
        rows[4] = '{24'hFEDCBA, 8'h00, 1'b0, 1'b0};
        rows[5] = '{24'h00ABCD, 8'h01, 1'b1, 1'b0};    // Key 0 freezes the display
        rows[6] = '{24'h0F0000, 8'hFE, 1'b0, 1'b0};    // Other keys change nothing
        rows[7] = '{24'hFF8001, 8'h00, 1'b0, 1'b0};
        rows[8] = '{24'h010000, 8'h00, 1'b0, 1'b0};
        rows[9] = '{24'h00FFFF, 8'h00, 1'b0, 1'b0};
        for (int r = FIXED_ROWS; r < NUM_ROWS; r++)
            rows[r] = '{24'h000000, 8'h00, 1'b0, 1'b1};

        repeat (2) @(posedge clk);
        #5;
        arst_n = 1'b1;

        // First frame carries the reset image
        wait (frame_count >= 1);
        for (int a = 0; a < 16; a++)
            check($sformatf("panel byte %0d", a), shown[a], 8'h00);
        check("command 0", cmd_log[0], 8'h40);
        check("command 1", cmd_log[1], 8'hC0);
        check("command 2", cmd_log[2], 8'h8F);
        check("command 3", cmd_log[3], 8'h42);
        check("mic_lr", {7'd0, mic_lr}, 8'h00);     // Left channel select

        shown_sample = '0;
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            @(posedge clk);
            #5;
            key_mask = rows[r].key_mask;
            fbase = frame_count;
            wait (frame_count >= fbase + 2);    // One full key read with the new mask

            @(posedge clk);
            #5;
            cur_sample = rows[r].rnd ? mic_sample_t'($random(seed)) : rows[r].sample;
            wbase = words_sent;
            wait (words_sent >= wbase + 2);
            fbase = frame_count;
            wait (frame_count >= fbase + 2);

            if (!rows[r].held)
                shown_sample = cur_sample;
            compare_image(shown_sample, rows[r].held);
        end

        failures = u_board_specific_top.u_tm1638.u_panel_assert.failures
                 + u_board_specific_top.u_mic.u_mic_assert.failures;
        if (failures == 0)
        begin
            $display("Test completed successfully");
            $finish;
        end
        else
        begin
            $display("%0d protocol assertions failed during the run", failures);
            $display("Test failed");
            $fatal(1, "assertion failures");
        end
    end

    // ------------------------------
    // Watchdog

    initial
    begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired: panel frames stopped before all rows were checked");
        $display("Test failed");
        $fatal(1, "timeout");
    end

endmodule
